// ==== ldpc_alu.f ====
hdl/alu_pkg.sv
hdl/alu_req_if.sv
hdl/alu_adder.sv
hdl/alu_shifter.sv
hdl/ldpc_simd.sv
hdl/alu_result_stage.sv
hdl/alu_top.sv
test/alu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the ALU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module alu_tb \
        -f ldpc_alu.f -o alu_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/alu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== test/alu_tb.sv ====
// Self-checking testbench for the LDPC-extended ALU
// Sends directed and random requests and checks every response against a reference model

`timescale 1ns/1ps

module alu_tb import alu_pkg::*; ();

    localparam int XLEN            = 32;
    localparam int LANES           = XLEN / LANE_W;
    localparam int CLK_HALF        = 2;
    localparam int RESET_CYCLES    = 16;
    localparam int SEED            = 18;
    localparam int N_WORD_EDGES    = 4;
    localparam int N_LANE_EDGES    = 8;
    localparam int N_RANDOM        = 600;
    localparam int N_EDGE_REQS     = 16 * N_WORD_EDGES * N_WORD_EDGES;
    localparam int N_SHIFT_REQS    = 3 * XLEN;
    localparam int N_LDPC_REQS     = 7 * N_LANE_EDGES * N_LANE_EDGES;
    localparam int TOTAL_REQS      = N_EDGE_REQS + N_SHIFT_REQS + N_LDPC_REQS + N_RANDOM;
    localparam int WATCHDOG_MARGIN = 64;

    logic            clk = 1'b0;
    logic            reset;
    logic            req_valid;
    alu_op_t         req_op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] imm;
    logic            rsp_valid;
    logic [XLEN-1:0] rsp_result;
    logic            rsp_branch;

    // Expected responses in request order
    logic [XLEN-1:0] exp_result_q [$];
    logic            exp_branch_q [$];
    alu_op_t         exp_op_q [$];
    int              n_req = 0;
    int              n_resp = 0;
    logic            accepted = 1'b0;
    logic [XLEN-1:0] last_result = '0;
    logic            last_branch = 1'b0;

    always #(CLK_HALF) clk = ~clk;

    alu_top #(.XLEN(XLEN)) u_alu_top (
        .clk_i       (clk),
        .reset_i     (reset),
        .valid_i     (req_valid),
        .op_i        (req_op),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .imm_i       (imm),
        .valid_o     (rsp_valid),
        .result_o    (rsp_result),
        .branch_o    (rsp_branch)
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int saturate(input int v);
        if (v > int'(LANE_MAX)) begin
            return int'(LANE_MAX);
        end else if (v < -int'(LANE_MAX)) begin
            return -int'(LANE_MAX);
        end
        return v;
    endfunction

    function automatic lane_t lane_predict(input alu_op_t op, input int x, input int y,
                                           input int z);
        int r;
        int big;
        big = (x > y) ? x : y;
        case (op)
            LDPC_MIN:         r = (x < y) ? x : y;
            LDPC_ABS:         r = (x < 0) ? -x : x;
            LDPC_ADD_SAT:     r = saturate(x + y);
            LDPC_SUB_SAT:     r = saturate(x - y);
            LDPC_MINMAX:      r = (z < big) ? z : big;
            LDPC_MIN_SORTING: r = (x != y) ? x : z;
            LDPC_RSIGN:       r = ((x < 0) != (y < 0)) ? -z : z;
            default:          r = 0;
        endcase
        // 128 folds back to -128
        return lane_t'(r);
    endfunction

    // Returns {branch, result}
    function automatic logic [XLEN:0] predict_response(input alu_op_t op,
                                                       input logic [XLEN-1:0] a,
                                                       input logic [XLEN-1:0] b,
                                                       input logic [XLEN-1:0] c);
        logic [XLEN-1:0] res;
        logic            br;
        lane_t           la;
        lane_t           lb;
        lane_t           lc;
        res = '0;
        br  = 1'b1;
        case (op)
            ADD:    res = a + b;
            SUB:    res = a - b;
            AND_OP: res = a & b;
            OR_OP:  res = a | b;
            XOR_OP: res = a ^ b;
            SLL:    res = a << b[4:0];
            SRL:    res = a >> b[4:0];
            SRA:    res = $signed(a) >>> b[4:0];
            SLTS:   res[0] = ($signed(a) < $signed(b));
            SLTU:   res[0] = (a < b);
            EQ:     br = (a == b);
            NE:     br = (a != b);
            LTS:    br = ($signed(a) < $signed(b));
            LTU:    br = (a < b);
            GES:    br = !($signed(a) < $signed(b));
            GEU:    br = !(a < b);
            default: begin
                for (int k = 0; k < LANES; k++) begin
                    la = a[k*LANE_W +: LANE_W];
                    lb = b[k*LANE_W +: LANE_W];
                    lc = c[k*LANE_W +: LANE_W];
                    res[k*LANE_W +: LANE_W] = lane_predict(op, la, lb, lc);
                end
            end
        endcase
        return {br, res};
    endfunction

    // ----------------------------------------
    // Driver tasks
    // ----------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run stopped on the first failure");
    endtask

    task automatic send_request(input alu_op_t op, input logic [XLEN-1:0] a,
                                input logic [XLEN-1:0] b, input logic [XLEN-1:0] c);
        logic [XLEN:0] expected;
        expected = predict_response(op, a, b, c);
        req_valid <= 1'b1;
        req_op    <= op;
        operand_a <= a;
        operand_b <= b;
        imm       <= c;
        exp_result_q.push_back(expected[XLEN-1:0]);
        exp_branch_q.push_back(expected[XLEN]);
        exp_op_q.push_back(op);
        n_req++;
        @(posedge clk);
    endtask

    task automatic idle_cycle();
        req_valid <= 1'b0;
        @(posedge clk);
    endtask

    // ----------------------------------------
    // Response checker
    // ----------------------------------------
    // What the DUT saw at the last edge
    always @(posedge clk) accepted <= req_valid;

    always @(negedge clk) begin : check_responses
        logic [XLEN-1:0] exp_result;
        logic            exp_branch;
        alu_op_t         exp_op;
        if (!reset) begin
            assert (rsp_valid === accepted)
                else abort_run($sformatf("error at %0t: valid_o is %b, expected %b",
                                         $time, rsp_valid, accepted));
            if (rsp_valid) begin
                if (exp_result_q.size() == 0) begin
                    abort_run("valid_o pulsed with no request outstanding");
                end else begin
                    exp_result = exp_result_q.pop_front();
                    exp_branch = exp_branch_q.pop_front();
                    exp_op     = exp_op_q.pop_front();
                    assert (rsp_result === exp_result && rsp_branch === exp_branch)
                        else abort_run($sformatf(
                            "error at %0t: %s gave result %h branch %b, expected %h %b",
                            $time, exp_op.name(), rsp_result, rsp_branch,
                            exp_result, exp_branch));
                    last_result = exp_result;
                    last_branch = exp_branch;
                    n_resp++;
                end
            end else begin
                // Idle cycles and the reset values
                assert (rsp_result === last_result && rsp_branch === last_branch)
                    else abort_run($sformatf(
                        "error at %0t: outputs changed to %h %b without a request",
                        $time, rsp_result, rsp_branch));
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        logic [XLEN-1:0] word_edges [N_WORD_EDGES];
        lane_t           lane_edges [N_LANE_EDGES];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] c;
        alu_op_t         op;

        void'($urandom(SEED));
        word_edges = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        // 0, 1, -1, 127, -127, -128, 126, -126
        lane_edges = '{8'h00, 8'h01, 8'hff, 8'h7f, 8'h81, 8'h80, 8'h7e, 8'h82};

        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = ADD;
        operand_a = '0;
        operand_b = '0;
        imm       = '0;
        a         = '0;
        b         = '0;
        c         = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (2) idle_cycle();

        // Back-to-back burst over all integer ops and edge operands
        for (int o = int'(ADD); o <= int'(GEU); o++) begin
            for (int i = 0; i < N_WORD_EDGES; i++) begin
                for (int j = 0; j < N_WORD_EDGES; j++) begin
                    send_request(alu_op_t'(o), word_edges[i], word_edges[j],
                                 word_edges[(i + j) % N_WORD_EDGES]);
                end
            end
        end

        // Every shift amount with the sign bit toggling
        for (int o = int'(SLL); o <= int'(SRA); o++) begin
            for (int s = 0; s < XLEN; s++) begin
                a         = $urandom();
                a[XLEN-1] = s[0];
                b         = $urandom();
                b[4:0]    = 5'(s);
                send_request(alu_op_t'(o), a, b, $urandom());
            end
        end

        // Lane saturation edges rotated across the lanes
        for (int o = int'(LDPC_MIN); o <= int'(LDPC_RSIGN); o++) begin
            for (int i = 0; i < N_LANE_EDGES; i++) begin
                for (int j = 0; j < N_LANE_EDGES; j++) begin
                    for (int k = 0; k < LANES; k++) begin
                        a[k*LANE_W +: LANE_W] = lane_edges[(i + k) % N_LANE_EDGES];
                        b[k*LANE_W +: LANE_W] = lane_edges[(j + k) % N_LANE_EDGES];
                        c[k*LANE_W +: LANE_W] = lane_edges[(i + j + k) % N_LANE_EDGES];
                    end
                    send_request(alu_op_t'(o), a, b, c);
                end
            end
        end

        // Random ops with occasional idle gaps and equal operands
        repeat (N_RANDOM) begin
            op = alu_op_t'(5'($urandom_range(int'(LDPC_RSIGN))));
            a  = $urandom();
            b  = ($urandom_range(3) == 0) ? a : $urandom();
            c  = $urandom();
            send_request(op, a, b, c);
            if ($urandom_range(3) == 0) begin
                idle_cycle();
            end
        end

        idle_cycle();
        repeat (4) idle_cycle();

        if (n_resp == n_req && exp_result_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("responses missing or left over at the end of the run");
        end
    end

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------
    initial begin : watchdog
        repeat (RESET_CYCLES + 2 * TOTAL_REQS + WATCHDOG_MARGIN) @(posedge clk);
        abort_run("timeout: the run did not finish in the expected number of cycles");
    end

endmodule

// ==== hdl/alu_top.sv ====
// Top level of the LDPC-extended ALU
// Packs the plain request ports into the request bus and wires the units

`timescale 1ns/1ps

module alu_top import alu_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            valid_i,
    input  alu_op_t         op_i,
    input  logic [XLEN-1:0] operand_a_i,
    input  logic [XLEN-1:0] operand_b_i,
    input  logic [XLEN-1:0] imm_i,
    output logic            valid_o,
    output logic [XLEN-1:0] result_o,
    output logic            branch_o
);

    logic [XLEN-1:0] sum;
    logic            less;
    logic            branch;
    logic [XLEN-1:0] shift_res;
    logic [XLEN-1:0] ldpc_res;

    alu_req_if #(.XLEN(XLEN)) req_if ();

    // Request packing
    assign req_if.valid     = valid_i;
    assign req_if.op        = op_i;
    assign req_if.operand_a = operand_a_i;
    assign req_if.operand_b = operand_b_i;
    assign req_if.imm       = imm_i;

    // ----------------------------------------
    // Function units
    // ----------------------------------------
    alu_adder #(.XLEN(XLEN)) u_adder (
        .req_i    (req_if),
        .sum_o    (sum),
        .less_o   (less),
        .branch_o (branch)
    );

    alu_shifter #(.XLEN(XLEN)) u_shifter (
        .req_i       (req_if),
        .shift_res_o (shift_res)
    );

    ldpc_simd #(.XLEN(XLEN)) u_ldpc_simd (
        .req_i      (req_if),
        .ldpc_res_o (ldpc_res)
    );

    alu_result_stage #(.XLEN(XLEN)) u_result_stage (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_i       (req_if),
        .sum_i       (sum),
        .less_i      (less),
        .branch_i    (branch),
        .shift_res_i (shift_res),
        .ldpc_res_i  (ldpc_res),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .branch_o    (branch_o)
    );

endmodule

// ==== hdl/alu_result_stage.sv ====
// Result select, bitwise logic and the single output register
// One cycle after an accepted request, valid_o pulses with its result

`timescale 1ns/1ps

module alu_result_stage import alu_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            reset_i,
    alu_req_if.unit         req_i,
    input  logic [XLEN-1:0] sum_i,
    input  logic            less_i,
    input  logic            branch_i,
    input  logic [XLEN-1:0] shift_res_i,
    input  logic [XLEN-1:0] ldpc_res_i,
    output logic            valid_o,
    output logic [XLEN-1:0] result_o,
    output logic            branch_o
);

    logic [XLEN-1:0] and_res;
    logic [XLEN-1:0] or_res;
    logic [XLEN-1:0] xor_res;
    logic [XLEN-1:0] result_d;

    assign and_res = req_i.operand_a & req_i.operand_b;
    assign or_res  = req_i.operand_a | req_i.operand_b;
    assign xor_res = req_i.operand_a ^ req_i.operand_b;

    // ----------------------------------------
    // Result mux
    // ----------------------------------------
    always_comb begin
        case (req_i.op)
            ADD, SUB:      result_d = sum_i;
            AND_OP:        result_d = and_res;
            OR_OP:         result_d = or_res;
            XOR_OP:        result_d = xor_res;
            SLL, SRL, SRA: result_d = shift_res_i;
            SLTS, SLTU:    result_d = {{(XLEN-1){1'b0}}, less_i};
            LDPC_MIN, LDPC_ABS, LDPC_ADD_SAT, LDPC_SUB_SAT,
            LDPC_MINMAX, LDPC_MIN_SORTING, LDPC_RSIGN:
                           result_d = ldpc_res_i;
            // Branch comparisons
            default:       result_d = '0;
        endcase
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            branch_o <= 1'b0;
        end else begin
            valid_o <= req_i.valid;
            // Hold the last result between requests
            if (req_i.valid) begin
                result_o <= result_d;
                branch_o <= branch_i;
            end
        end
    end

    // A non-branch request answers one cycle later with the branch flag set
    a_valid_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        req_i.valid && !(req_i.op inside {EQ, NE, LTS, LTU, GES, GEU})
            |=> valid_o && branch_o);

endmodule

// ==== hdl/ldpc_simd.sv ====
// Packed min-sum operations on 8-bit signed lanes for LDPC decoding
// A, B and imm are split into lanes and every lane runs the same op

`timescale 1ns/1ps

module ldpc_simd import alu_pkg::*; #(
    parameter int XLEN = 32
) (
    alu_req_if.unit         req_i,
    output logic [XLEN-1:0] ldpc_res_o
);

    localparam int LANES = XLEN / LANE_W;

    // Lanes must tile the word exactly
    if ((XLEN % LANE_W) != 0) begin : g_width_check
        $error("ldpc_simd: XLEN must be a multiple of LANE_W");
    end

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lane_t     a;
        lane_t     b;
        lane_t     c;
        lane_ext_t sum;
        lane_ext_t diff;
        lane_t     add_sat;
        lane_t     sub_sat;
        logic      a_ge_b;
        lane_t     lane_min;
        lane_t     lane_max;
        lane_t     minmax;
        lane_t     min_sort;
        lane_t     abs_a;
        lane_t     rsign;
        lane_t     lane_res;

        assign a = lane_t'(req_i.operand_a[i*LANE_W +: LANE_W]);
        assign b = lane_t'(req_i.operand_b[i*LANE_W +: LANE_W]);
        assign c = lane_t'(req_i.imm[i*LANE_W +: LANE_W]);

        // ----------------------------------------
        // Saturating add and subtract
        // ----------------------------------------
        assign sum  = lane_ext_t'(a) + lane_ext_t'(b);
        assign diff = lane_ext_t'(a) - lane_ext_t'(b);

        assign add_sat = (sum > LANE_MAX) ? LANE_MAX :
                         (sum < LANE_MIN) ? LANE_MIN : lane_t'(sum);
        assign sub_sat = (diff > LANE_MAX) ? LANE_MAX :
                         (diff < LANE_MIN) ? LANE_MIN : lane_t'(diff);

        // ----------------------------------------
        // Compare based ops
        // ----------------------------------------
        assign a_ge_b   = (a >= b);
        assign lane_min = a_ge_b ? b : a;
        assign lane_max = a_ge_b ? a : b;

        // Clip the larger input against imm
        assign minmax   = (c >= lane_max) ? lane_max : c;

        // Keep A unless it ties with B
        assign min_sort = (a != b) ? a : c;

        // -128 wraps to itself
        assign abs_a    = a[LANE_W-1] ? -a : a;

        // Flip the message sign when A and B disagree
        assign rsign    = (a[LANE_W-1] ^ b[LANE_W-1]) ? -c : c;

        always_comb begin
            case (req_i.op)
                LDPC_MIN:         lane_res = lane_min;
                LDPC_ABS:         lane_res = abs_a;
                LDPC_ADD_SAT:     lane_res = add_sat;
                LDPC_SUB_SAT:     lane_res = sub_sat;
                LDPC_MINMAX:      lane_res = minmax;
                LDPC_MIN_SORTING: lane_res = min_sort;
                LDPC_RSIGN:       lane_res = rsign;
                default:          lane_res = '0;
            endcase
        end

        assign ldpc_res_o[i*LANE_W +: LANE_W] = lane_res;
    end

endmodule

// ==== hdl/alu_shifter.sv ====
// Logical and arithmetic shifter built around one right shifter
// Left shifts reverse the operand before and after the shift

`timescale 1ns/1ps

module alu_shifter import alu_pkg::*; #(
    parameter int XLEN = 32
) (
    alu_req_if.unit         req_i,
    output logic [XLEN-1:0] shift_res_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    typedef logic [SHAMT_W-1:0] shamt_t;

    logic            shift_left;
    logic            shift_arith;
    shamt_t          shamt;
    logic [XLEN-1:0] operand_a_rev;
    logic [XLEN-1:0] shift_in;
    logic [XLEN:0]   shift_in_ext;
    logic [XLEN:0]   shift_right;
    logic [XLEN-1:0] shift_right_rev;

    assign shift_left  = (req_i.op == SLL);
    assign shift_arith = (req_i.op == SRA);
    assign shamt       = req_i.operand_b[SHAMT_W-1:0];

    // Bit reversal on both sides of the shifter
    for (genvar k = 0; k < XLEN; k++) begin : g_rev
        assign operand_a_rev[k]   = req_i.operand_a[XLEN-1-k];
        assign shift_right_rev[k] = shift_right[XLEN-1-k];
    end

    assign shift_in = shift_left ? operand_a_rev : req_i.operand_a;

    // Sign bit only fills for SRA
    assign shift_in_ext = {shift_arith & shift_in[XLEN-1], shift_in};
    assign shift_right  = $unsigned($signed(shift_in_ext) >>> shamt);

    assign shift_res_o = shift_left ? shift_right_rev : shift_right[XLEN-1:0];

endmodule

// ==== hdl/alu_adder.sv ====
// Shared adder and subtractor with set-less-than and branch comparison
// Purely combinational and feeds the result stage

`timescale 1ns/1ps

module alu_adder import alu_pkg::*; #(
    parameter int XLEN = 32
) (
    alu_req_if.unit         req_i,
    output logic [XLEN-1:0] sum_o,
    output logic            less_o,
    output logic            branch_o
);

    logic            negate_b;
    logic [XLEN-1:0] operand_b_neg;
    logic            zero_flag;
    logic            signed_cmp;
    logic            a_msb;
    logic            b_msb;

    // ----------------------------------------
    // Adder
    // ----------------------------------------
    // Subtract for SUB and for every comparison
    always_comb begin
        case (req_i.op)
            SUB, SLTS, SLTU, EQ, NE, LTS, LTU, GES, GEU: negate_b = 1'b1;
            default:                                     negate_b = 1'b0;
        endcase
    end

    assign operand_b_neg = req_i.operand_b ^ {XLEN{negate_b}};
    assign sum_o         = req_i.operand_a + operand_b_neg + XLEN'(negate_b);
    assign zero_flag     = ~|sum_o;

    // ----------------------------------------
    // Comparison
    // ----------------------------------------
    assign signed_cmp = (req_i.op == SLTS) || (req_i.op == LTS) || (req_i.op == GES);
    assign a_msb      = req_i.operand_a[XLEN-1];
    assign b_msb      = req_i.operand_b[XLEN-1];

    // Equal top bits means the difference cannot overflow
    always_comb begin
        if (a_msb != b_msb) begin
            less_o = signed_cmp ? a_msb : b_msb;
        end else begin
            less_o = sum_o[XLEN-1];
        end
    end

    // Branch resolve with non-branch ops reporting taken
    always_comb begin
        case (req_i.op)
            EQ:       branch_o = zero_flag;
            NE:       branch_o = ~zero_flag;
            LTS, LTU: branch_o = less_o;
            GES, GEU: branch_o = ~less_o;
            default:  branch_o = 1'b1;
        endcase
    end

    // Known operands must give a known sum
    always_comb begin
        if (req_i.valid == 1'b1) begin
            assert (!$isunknown(sum_o))
                else $error("alu_adder: unknown sum on a valid request");
        end
    end

endmodule

// ==== hdl/alu_req_if.sv ====
// One ALU request as seen by the function units
// The top level drives it through src, every unit reads it through unit

`timescale 1ns/1ps

interface alu_req_if import alu_pkg::*; #(
    parameter int XLEN = 32
) ();

    logic            valid;
    alu_op_t         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] imm;

    // Request source
    modport src (
        output valid, op, operand_a, operand_b, imm
    );

    // Function units and result stage
    modport unit (
        input valid, op, operand_a, operand_b, imm
    );

endinterface

// ==== hdl/alu_pkg.sv ====
// Operation encoding, lane types and lane constants for the LDPC-extended ALU
// Imported by wildcard into every RTL unit and into the testbench

package alu_pkg;

    // ----------------------------------------
    // Operations
    // ----------------------------------------
    typedef enum logic [4:0] {
        // Adder
        ADD,
        SUB,
        // Bitwise logic
        AND_OP,
        OR_OP,
        XOR_OP,
        // Shifts
        SLL,
        SRL,
        SRA,
        // Set less than
        SLTS,
        SLTU,
        // Branch comparisons with a zero result
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        // LDPC min-sum lane operations
        LDPC_MIN,
        LDPC_ABS,
        LDPC_ADD_SAT,
        LDPC_SUB_SAT,
        LDPC_MINMAX,
        LDPC_MIN_SORTING,
        LDPC_RSIGN
    } alu_op_t;

    // ----------------------------------------
    // LDPC lanes
    // ----------------------------------------
    localparam int LANE_W = 8;

    // One signed message per lane
    typedef logic signed [LANE_W-1:0] lane_t;

    // Extra bit to catch lane overflow before saturation
    typedef logic signed [LANE_W:0] lane_ext_t;

    // Symmetric saturation bounds so add and sub never produce -128
    localparam lane_t LANE_MAX = lane_t'((2 ** (LANE_W - 1)) - 1);
    localparam lane_t LANE_MIN = -LANE_MAX;

endpackage
